// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_uart
FILELIST = sim.f
OBJDIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	out=$$(./$(OBJDIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJDIR)

// File: sim.f
uart_pkg.sv
stream_fifo.sv
uart_tx.sv
uart_rx.sv
uart_stream.sv
uart_axil_regs.sv
uart_axil_top.sv
tb_uart.sv

// File: stream_fifo.sv
`timescale 1ns/1ps

module stream_fifo #(
    parameter int DW = 8,
    parameter int AW = 4
) (
    input  logic          clk,
    input  logic          arst_n,
    input  logic [DW-1:0] in_data,
    input  logic          in_valid,
    output logic          in_ready,
    output logic [DW-1:0] out_data,
    output logic          out_valid,
    input  logic          out_ready,
    output logic          empty,
    output logic          full
);

    logic [DW-1:0] mem [2**AW];
    logic [AW:0]   wr_ptr;
    logic [AW:0]   rd_ptr;
    logic          push;
    logic          pop;

    assign empty     = (wr_ptr == rd_ptr);
    assign full      = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    assign in_ready  = !full;
    assign out_valid = !empty;
    assign out_data  = mem[rd_ptr[AW-1:0]];  // Head word, no read latency
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[AW-1:0]] <= in_data;
        end
    end

    // Occupancy never exceeds the depth
    a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
        (wr_ptr - rd_ptr) <= (AW+1)'(2**AW));

endmodule

// File: tb_uart.sv
`timescale 1ns/1ps

module tb_uart;
    import uart_pkg::*;

    localparam int PRESCALE_RUN = 2;
    localparam int BIT_CYC      = PRESCALE_RUN * 8;
    localparam int FRAME_CYC    = BIT_CYC * 10;
    localparam int FIFO_DEPTH   = 2 ** FIFO_AW;
    localparam int MAX_CYCLES   = 40 * FRAME_CYC * 3 + 800;  // ~40 frames, 3x margin

    logic                clk;
    logic                arst_n;
    logic [AXI_AW-1:0]   awaddr;
    logic                awvalid;
    logic                awready;
    logic [AXI_DW-1:0]   wdata;
    logic [AXI_DW/8-1:0] wstrb;
    logic                wvalid;
    logic                wready;
    logic [1:0]          bresp;
    logic                bvalid;
    logic                bready;
    logic [AXI_AW-1:0]   araddr;
    logic                arvalid;
    logic                arready;
    logic [AXI_DW-1:0]   rdata;
    logic [1:0]          rresp;
    logic                rvalid;
    logic                rready;
    logic                txd;
    logic                rxd;

    logic              use_drv;     // Serial driver instead of loopback
    logic              drv_rxd;
    int                errors;
    int                checks;
    int                cycles;
    integer            seed;
    logic [1:0]        resp;
    logic [AXI_DW-1:0] rword;
    logic [DATA_W-1:0] sent [$];
    logic [DATA_W-1:0] rnd_byte;

    assign rxd = use_drv ? drv_rxd : txd;

    uart_axil_top uut (
        .clk     (clk),
        .arst_n  (arst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .txd     (txd),
        .rxd     (rxd)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // ******************************
    // Bus protocol checks
    // ******************************
    a_aw_w_pair: assert property (@(posedge clk) disable iff (!arst_n)
        awready == wready)
        else begin
            errors = errors + 1;
            $display("awready and wready did not move together");
        end

    a_wr_resp_time: assert property (@(posedge clk) disable iff (!arst_n)
        awvalid && awready |=> bvalid)
        else begin
            errors = errors + 1;
            $display("Write response did not follow the AW/W handshake by one cycle");
        end

    a_rd_resp_time: assert property (@(posedge clk) disable iff (!arst_n)
        arvalid && arready |=> rvalid)
        else begin
            errors = errors + 1;
            $display("Read data did not follow the AR handshake by one cycle");
        end

    a_rd_hold: assert property (@(posedge clk) disable iff (!arst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else begin
            errors = errors + 1;
            $display("Read data dropped or changed before rready");
        end

    // ******************************
    // Helpers
    // ******************************
    task automatic check_equal(input string name, input logic [AXI_DW-1:0] exp,
                               input logic [AXI_DW-1:0] act);
        checks = checks + 1;
        assert (act === exp) else begin
            errors = errors + 1;
            $display("FAILED %s: expected 0x%0h, actual 0x%0h", name, exp, act);
        end
    endtask

    task automatic axi_write(input logic [AXI_AW-1:0] addr, input logic [AXI_DW-1:0] data,
                             output logic [1:0] wr_resp);
        @(posedge clk);
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= '1;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        @(negedge clk);
        while (!awready) @(negedge clk);
        @(posedge clk);                      // Handshake edge
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        wr_resp = bresp;
        @(posedge clk);                      // Response waits one cycle
        bready <= 1'b1;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [AXI_AW-1:0] addr, output logic [AXI_DW-1:0] data,
                            output logic [1:0] rd_resp);
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        arvalid <= 1'b0;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        data    = rdata;
        rd_resp = rresp;
        @(posedge clk);                      // Read data waits one cycle
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic wait_tx_idle();
        logic [AXI_DW-1:0] st;
        logic [1:0]        r;
        do begin
            axi_read(REG_STATUS, st, r);
        end while (st[ST_TX_ACTIVE]);
    endtask

    // Expected 8N1 frame on txd, one level per bit for BIT_CYC cycles
    task automatic check_frame(input logic [DATA_W-1:0] data);
        logic [9:0] frame;
        int         b;
        int         c;
        frame = {1'b1, data, 1'b0};
        @(negedge clk);
        while (txd) @(negedge clk);
        for (b = 0; b < 10; b++) begin
            for (c = 0; c < BIT_CYC; c++) begin
                if (b != 0 || c != 0) begin
                    @(negedge clk);
                end
                check_equal($sformatf("txd bit %0d cycle %0d", b, c),
                            {31'd0, frame[b]}, {31'd0, txd});
            end
        end
        @(negedge clk);
        check_equal("txd idle after stop", 32'd1, {31'd0, txd});
    endtask

    task automatic send_serial(input logic [DATA_W-1:0] data, input logic stop_bit);
        logic [9:0] frame;
        int         b;
        frame = {stop_bit, data, 1'b0};
        for (b = 0; b < 10; b++) begin
            @(posedge clk);
            drv_rxd <= frame[b];
            repeat (BIT_CYC - 1) @(posedge clk);
        end
        @(posedge clk);
        drv_rxd <= 1'b1;
    endtask

    // ******************************
    // Tests
    // ******************************
    initial begin
        arst_n  = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        use_drv = 1'b0;
        drv_rxd = 1'b1;
        errors  = 0;
        checks  = 0;
        cycles  = 0;
        seed    = 32'ha686;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;

        // Register reset and readback
        axi_read(REG_PRESCALE, rword, resp);
        check_equal("prescale reset", 32'd1, rword);
        axi_read(REG_STATUS, rword, resp);
        check_equal("status reset", 32'd0, rword);
        axi_write(REG_PRESCALE, PRESCALE_RUN, resp);
        check_equal("prescale write resp", {30'd0, RESP_OKAY}, {30'd0, resp});
        axi_read(REG_PRESCALE, rword, resp);
        check_equal("prescale readback", PRESCALE_RUN, rword);
        axi_read(4'h2, rword, resp);
        check_equal("unmapped read resp", {30'd0, RESP_SLVERR}, {30'd0, resp});
        check_equal("unmapped read data", 32'd0, rword);

        // Loopback data
        for (int i = 0; i < 10; i++) begin
            rnd_byte = DATA_W'($random(seed));
            sent.push_back(rnd_byte);
            axi_write(REG_TXDATA, {24'd0, rnd_byte}, resp);
            check_equal("loopback write resp", {30'd0, RESP_OKAY}, {30'd0, resp});
        end
        while (sent.size() > 0) begin
            do begin
                axi_read(REG_STATUS, rword, resp);
            end while (!rword[ST_RX_AVAIL]);
            axi_read(REG_RXDATA, rword, resp);
            check_equal("loopback byte", {24'd0, sent.pop_front()}, rword);
        end

        // Bit timing and idle line
        repeat (BIT_CYC) begin
            @(negedge clk);
            check_equal("txd idle", 32'd1, {31'd0, txd});
        end
        fork
            axi_write(REG_TXDATA, 32'h55, resp);
            check_frame(8'h55);
        join
        axi_read(REG_RXDATA, rword, resp);
        check_equal("timing frame loopback", 32'h55, rword);

        // TX back-pressure, receiver held idle
        @(posedge clk);
        use_drv <= 1'b1;
        for (int i = 0; i < FIFO_DEPTH + 2; i++) begin
            axi_write(REG_TXDATA, i, resp);
            check_equal($sformatf("tx push %0d resp", i),
                        (i <= FIFO_DEPTH) ? {30'd0, RESP_OKAY} : {30'd0, RESP_SLVERR},
                        {30'd0, resp});
        end
        axi_read(REG_STATUS, rword, resp);
        check_equal("tx full flag", 32'd1, {31'd0, rword[ST_TX_FULL]});
        axi_read(REG_RXDATA, rword, resp);
        check_equal("empty rx read", 32'd1 << RX_EMPTY_BIT, rword);
        wait_tx_idle();

        // Frame error from the serial driver
        send_serial(8'ha5, 1'b0);
        repeat (2 * BIT_CYC) @(posedge clk);
        axi_read(REG_STATUS, rword, resp);
        check_equal("frame error status", 32'd1 << ST_FRAME_ERR, rword);
        axi_read(REG_RXDATA, rword, resp);
        check_equal("no byte after bad frame", 32'd1 << RX_EMPTY_BIT, rword);
        axi_write(REG_STATUS, 32'd1 << ST_FRAME_ERR, resp);
        axi_read(REG_STATUS, rword, resp);
        check_equal("frame error cleared", 32'd0, rword);

        // Overrun, one byte more than the RX FIFO holds
        @(posedge clk);
        use_drv <= 1'b0;
        for (int i = 0; i < FIFO_DEPTH + 1; i++) begin
            rnd_byte = DATA_W'($random(seed));
            sent.push_back(rnd_byte);
            axi_write(REG_TXDATA, {24'd0, rnd_byte}, resp);
            check_equal("overrun write resp", {30'd0, RESP_OKAY}, {30'd0, resp});
        end
        wait_tx_idle();
        repeat (BIT_CYC) @(posedge clk);
        axi_read(REG_STATUS, rword, resp);
        check_equal("overrun status",
                    (32'd1 << ST_RX_ACTIVE) | (32'd1 << ST_OVERRUN) | (32'd1 << ST_RX_AVAIL),
                    rword);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            axi_read(REG_RXDATA, rword, resp);
            check_equal($sformatf("overrun byte %0d", i), {24'd0, sent[i]}, rword);
        end
        axi_read(REG_RXDATA, rword, resp);
        check_equal("lost byte not queued", 32'd1 << RX_EMPTY_BIT, rword);
        axi_write(REG_STATUS, 32'd1 << ST_OVERRUN, resp);
        axi_read(REG_STATUS, rword, resp);
        check_equal("overrun cleared", 32'd0, rword);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: uart_axil_regs.sv
`timescale 1ns/1ps

module uart_axil_regs (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic [uart_pkg::AXI_AW-1:0]     awaddr,
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [uart_pkg::AXI_DW-1:0]     wdata,
    input  logic [uart_pkg::AXI_DW/8-1:0]   wstrb,
    input  logic                            wvalid,
    output logic                            wready,
    output logic [1:0]                      bresp,
    output logic                            bvalid,
    input  logic                            bready,
    input  logic [uart_pkg::AXI_AW-1:0]     araddr,
    input  logic                            arvalid,
    output logic                            arready,
    output logic [uart_pkg::AXI_DW-1:0]     rdata,
    output logic [1:0]                      rresp,
    output logic                            rvalid,
    input  logic                            rready,
    output logic [uart_pkg::PRESCALE_W-1:0] prescale,
    output logic [uart_pkg::DATA_W-1:0]     tx_data,
    output logic                            tx_valid,
    input  logic                            tx_ready,
    input  logic [uart_pkg::DATA_W-1:0]     rx_data,
    input  logic                            rx_valid,
    output logic                            rx_ready,
    input  logic [3:0]                      status_raw,
    input  logic                            rx_avail,
    input  logic                            tx_full
);
    import uart_pkg::*;

    logic              wr_hs;
    logic              rd_hs;
    logic              status_wr;
    logic              overrun_q;
    logic              frame_err_q;
    logic [1:0]        wr_resp;
    logic [1:0]        rd_resp;
    logic [AXI_DW-1:0] rd_word;

    // ******************************
    // Handshakes and stream strobes
    // ******************************
    assign wr_hs     = awvalid && wvalid && !bvalid;
    assign rd_hs     = arvalid && !rvalid;
    assign awready   = wr_hs;
    assign wready    = wr_hs;
    assign arready   = rd_hs;
    assign status_wr = wr_hs && (awaddr == REG_STATUS);

    assign tx_valid = wr_hs && (awaddr == REG_TXDATA) && wstrb[0];
    assign tx_data  = wdata[DATA_W-1:0];
    assign rx_ready = rd_hs && (araddr == REG_RXDATA);   // Pop on AR handshake

    always_comb begin
        case (awaddr)
            REG_PRESCALE, REG_STATUS: wr_resp = RESP_OKAY;
            REG_TXDATA:               wr_resp = (tx_valid && !tx_ready) ? RESP_SLVERR : RESP_OKAY;
            default:                  wr_resp = RESP_SLVERR;
        endcase
    end

    always_comb begin
        rd_word = '0;
        rd_resp = RESP_OKAY;
        case (araddr)
            REG_PRESCALE: rd_word[PRESCALE_W-1:0] = prescale;
            REG_STATUS: begin
                rd_word[ST_TX_ACTIVE] = status_raw[ST_TX_ACTIVE];
                rd_word[ST_RX_ACTIVE] = status_raw[ST_RX_ACTIVE];
                rd_word[ST_OVERRUN]   = overrun_q;
                rd_word[ST_FRAME_ERR] = frame_err_q;
                rd_word[ST_RX_AVAIL]  = rx_avail;
                rd_word[ST_TX_FULL]   = tx_full;
            end
            REG_RXDATA: begin
                if (rx_valid) begin
                    rd_word[DATA_W-1:0] = rx_data;
                end else begin
                    rd_word[RX_EMPTY_BIT] = 1'b1;
                end
            end
            default: rd_resp = RESP_SLVERR;
        endcase
    end

    // ******************************
    // Registers
    // ******************************
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bvalid      <= 1'b0;
            rvalid      <= 1'b0;
            prescale    <= PRESCALE_RST;
            overrun_q   <= 1'b0;
            frame_err_q <= 1'b0;
        end else begin
            if (wr_hs) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_hs) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            if (wr_hs && awaddr == REG_PRESCALE) begin
                prescale <= wdata[PRESCALE_W-1:0];
            end
            // New events win over a clear in the same cycle
            overrun_q   <= status_raw[ST_OVERRUN] ||
                           (overrun_q && !(status_wr && wdata[ST_OVERRUN]));
            frame_err_q <= status_raw[ST_FRAME_ERR] ||
                           (frame_err_q && !(status_wr && wdata[ST_FRAME_ERR]));
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs) begin
            bresp <= wr_resp;
        end
        if (rd_hs) begin
            rdata <= rd_word;
            rresp <= rd_resp;
        end
    end

    // Write response is held until the host takes it
    a_bvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
        bvalid && !bready |=> bvalid && $stable(bresp));

endmodule

// File: uart_axil_top.sv
`timescale 1ns/1ps

module uart_axil_top (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic [uart_pkg::AXI_AW-1:0]   awaddr,
    input  logic                          awvalid,
    output logic                          awready,
    input  logic [uart_pkg::AXI_DW-1:0]   wdata,
    input  logic [uart_pkg::AXI_DW/8-1:0] wstrb,
    input  logic                          wvalid,
    output logic                          wready,
    output logic [1:0]                    bresp,
    output logic                          bvalid,
    input  logic                          bready,
    input  logic [uart_pkg::AXI_AW-1:0]   araddr,
    input  logic                          arvalid,
    output logic                          arready,
    output logic [uart_pkg::AXI_DW-1:0]   rdata,
    output logic [1:0]                    rresp,
    output logic                          rvalid,
    input  logic                          rready,
    output logic                          txd,
    input  logic                          rxd
);
    import uart_pkg::*;

    logic [PRESCALE_W-1:0] prescale;
    logic [DATA_W-1:0]     tx_data;
    logic                  tx_valid;
    logic                  tx_ready;
    logic [DATA_W-1:0]     rx_data;
    logic                  rx_valid;
    logic                  rx_ready;
    logic [3:0]            status_raw;
    logic                  rx_avail;
    logic                  tx_full;

    uart_axil_regs u_regs (
        .clk        (clk),
        .arst_n     (arst_n),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .prescale   (prescale),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .rx_ready   (rx_ready),
        .status_raw (status_raw),
        .rx_avail   (rx_avail),
        .tx_full    (tx_full)
    );

    uart_stream u_stream (
        .clk        (clk),
        .arst_n     (arst_n),
        .prescale   (prescale),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .rx_ready   (rx_ready),
        .status_raw (status_raw),
        .rx_avail   (rx_avail),
        .tx_full    (tx_full),
        .txd        (txd),
        .rxd        (rxd)
    );

endmodule

// File: uart_pkg.sv
package uart_pkg;

    // ******************************
    // Widths
    // ******************************
    localparam int DATA_W       = 8;
    localparam int FIFO_AW      = 4;   // 16 entries
    localparam int PRESCALE_W   = 16;
    localparam int AXI_AW       = 4;
    localparam int AXI_DW       = 32;

    localparam logic [PRESCALE_W-1:0] PRESCALE_RST = PRESCALE_W'(1);

    // ******************************
    // Register map
    // ******************************
    localparam logic [AXI_AW-1:0] REG_PRESCALE = 4'h0;
    localparam logic [AXI_AW-1:0] REG_STATUS   = 4'h4;  // Write 1 clears error bits
    localparam logic [AXI_AW-1:0] REG_TXDATA   = 4'h8;
    localparam logic [AXI_AW-1:0] REG_RXDATA   = 4'hC;  // Read pops

    // Status bits, low four match the raw status from the stream block
    localparam int ST_TX_ACTIVE = 0;
    localparam int ST_RX_ACTIVE = 1;
    localparam int ST_OVERRUN   = 2;
    localparam int ST_FRAME_ERR = 3;
    localparam int ST_RX_AVAIL  = 4;
    localparam int ST_TX_FULL   = 5;

    localparam int RX_EMPTY_BIT = 8;    // Set in RXDATA when nothing was queued

    // ******************************
    // AXI responses
    // ******************************
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// File: uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            rxd,
    input  logic [uart_pkg::PRESCALE_W-1:0] prescale,
    output logic [uart_pkg::DATA_W-1:0]     out_data,
    output logic                            out_valid,
    input  logic                            out_ready,
    output logic                            busy,
    output logic                            overrun_err,
    output logic                            frame_err
);
    import uart_pkg::*;

    logic [2:0]            rxd_sync;
    logic                  rxd_s;
    logic                  start_edge;
    logic [PRESCALE_W+2:0] bit_len;
    logic [PRESCALE_W+2:0] baud_cnt;
    logic [3:0]            bit_cnt;    // 10 start, 9..2 data, 1 stop
    logic [DATA_W-1:0]     data_sr;
    logic                  sample;

    assign rxd_s       = rxd_sync[1];
    assign start_edge  = rxd_sync[2] && !rxd_sync[1];
    assign bit_len     = {prescale, 3'b000};
    assign sample      = busy && (baud_cnt == '0);
    assign out_data    = data_sr;
    assign overrun_err = out_valid && !out_ready;  // Byte offered to a full FIFO

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rxd_sync <= 3'b111;
        end else begin
            rxd_sync <= {rxd_sync[1:0], rxd};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy      <= 1'b0;
            bit_cnt   <= '0;
            baud_cnt  <= '0;
            out_valid <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            frame_err <= 1'b0;
            if (!busy) begin
                if (start_edge) begin
                    busy     <= 1'b1;
                    bit_cnt  <= 4'd10;
                    baud_cnt <= {1'b0, prescale, 2'b00} - 1'b1;  // Half a bit
                end
            end else if (baud_cnt != '0) begin
                baud_cnt <= baud_cnt - 1'b1;
            end else begin
                bit_cnt  <= bit_cnt - 1'b1;
                baud_cnt <= bit_len - 1'b1;
                if (bit_cnt == 4'd10 && rxd_s) begin
                    busy <= 1'b0;            // Glitch, not a start bit
                end else if (bit_cnt == 4'd1) begin
                    busy <= 1'b0;
                    if (rxd_s) begin
                        out_valid <= 1'b1;
                    end else begin
                        frame_err <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sample && bit_cnt inside {[4'd2:4'd9]}) begin
            data_sr <= {rxd_s, data_sr[DATA_W-1:1]};   // LSB first
        end
    end

    // A bad frame is never handed on, neither now nor a cycle later
    a_frame_no_data: assert property (@(posedge clk) disable iff (!arst_n)
        frame_err |-> !out_valid ##1 !out_valid);

endmodule

// File: uart_stream.sv
`timescale 1ns/1ps

module uart_stream (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic [uart_pkg::PRESCALE_W-1:0] prescale,
    input  logic [uart_pkg::DATA_W-1:0]     tx_data,
    input  logic                            tx_valid,
    output logic                            tx_ready,
    output logic [uart_pkg::DATA_W-1:0]     rx_data,
    output logic                            rx_valid,
    input  logic                            rx_ready,
    output logic [3:0]                      status_raw,
    output logic                            rx_avail,
    output logic                            tx_full,
    output logic                            txd,
    input  logic                            rxd
);
    import uart_pkg::*;

    logic [DATA_W-1:0] tx_head;
    logic              tx_head_valid;
    logic              tx_head_ready;
    logic              tx_fifo_empty;
    logic              tx_busy;

    logic [DATA_W-1:0] rx_byte;
    logic              rx_byte_valid;
    logic              rx_byte_ready;
    logic              rx_fifo_empty;
    logic              rx_busy;
    logic              overrun_err;
    logic              frame_err;

    assign status_raw[ST_TX_ACTIVE] = tx_busy || !tx_fifo_empty;
    assign status_raw[ST_RX_ACTIVE] = rx_busy || !rx_fifo_empty;
    assign status_raw[ST_OVERRUN]   = overrun_err;
    assign status_raw[ST_FRAME_ERR] = frame_err;
    assign rx_avail                 = !rx_fifo_empty;

    stream_fifo #(.DW(DATA_W), .AW(FIFO_AW)) tx_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_data   (tx_data),
        .in_valid  (tx_valid),
        .in_ready  (tx_ready),
        .out_data  (tx_head),
        .out_valid (tx_head_valid),
        .out_ready (tx_head_ready),
        .empty     (tx_fifo_empty),
        .full      (tx_full)
    );

    uart_tx u_tx (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_data  (tx_head),
        .in_valid (tx_head_valid),
        .in_ready (tx_head_ready),
        .prescale (prescale),
        .txd      (txd),
        .busy     (tx_busy)
    );

    uart_rx u_rx (
        .clk         (clk),
        .arst_n      (arst_n),
        .rxd         (rxd),
        .prescale    (prescale),
        .out_data    (rx_byte),
        .out_valid   (rx_byte_valid),
        .out_ready   (rx_byte_ready),
        .busy        (rx_busy),
        .overrun_err (overrun_err),
        .frame_err   (frame_err)
    );

    stream_fifo #(.DW(DATA_W), .AW(FIFO_AW)) rx_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_data   (rx_byte),
        .in_valid  (rx_byte_valid),
        .in_ready  (rx_byte_ready),
        .out_data  (rx_data),
        .out_valid (rx_valid),
        .out_ready (rx_ready),
        .empty     (rx_fifo_empty),
        .full      ()
    );

endmodule

// File: uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic [uart_pkg::DATA_W-1:0]     in_data,
    input  logic                            in_valid,
    output logic                            in_ready,
    input  logic [uart_pkg::PRESCALE_W-1:0] prescale,
    output logic                            txd,
    output logic                            busy
);
    import uart_pkg::*;

    logic [PRESCALE_W+2:0] bit_len;
    logic [PRESCALE_W+2:0] baud_cnt;
    logic [3:0]            bit_cnt;    // Bits left after the current one
    logic [DATA_W:0]       data_sr;    // Stop bit above the data
    logic                  load;
    logic                  shift;

    assign bit_len  = {prescale, 3'b000};    // prescale x 8 clocks
    assign in_ready = !busy;
    assign load     = in_valid && !busy;
    assign shift    = busy && (baud_cnt == '0) && (bit_cnt != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy     <= 1'b0;
            txd      <= 1'b1;
            bit_cnt  <= '0;
            baud_cnt <= '0;
        end else if (load) begin
            busy     <= 1'b1;
            txd      <= 1'b0;                // Start bit
            bit_cnt  <= 4'd9;
            baud_cnt <= bit_len - 1'b1;
        end else if (busy) begin
            if (baud_cnt != '0) begin
                baud_cnt <= baud_cnt - 1'b1;
            end else if (shift) begin
                txd      <= data_sr[0];
                bit_cnt  <= bit_cnt - 1'b1;
                baud_cnt <= bit_len - 1'b1;
            end else begin
                busy <= 1'b0;                // Stop bit done
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            data_sr <= {1'b1, in_data};
        end else if (shift) begin
            data_sr <= {1'b1, data_sr[DATA_W:1]};
        end
    end

    // Idle line stays at mark level
    a_idle_high: assert property (@(posedge clk) disable iff (!arst_n)
        !busy |-> txd);

endmodule
